// File: logic/time_pkg.sv
package time_pkg;

  // clock configuration widths
  localparam int unit_len_w = 16;
  localparam int epoch_len_w = 10;
  localparam int epoch_w = 32;

  // epochs the host may fall behind before waits get dropped
  localparam int squash_thr = 1;

  // host command word layout
  localparam int op_w = 3;
  localparam int arg_w = 29;

  // clocks per time unit
  typedef logic [unit_len_w-1:0] unit_len_t;
  // units per epoch, also used for wait lengths
  typedef logic [epoch_len_w-1:0] epoch_len_t;
  // epochs since the last time restart
  typedef logic [epoch_w-1:0] epoch_t;

  // data word handed to the device
  typedef logic [arg_w-1:0] stream_word_t;

  // codes 6 and 7 are unused and get acked without effect
  typedef enum logic [op_w-1:0] {
    op_unit_len   = 3'd0,
    op_epoch_len  = 3'd1,
    op_reset_time = 3'd2,
    op_host_epoch = 3'd3,
    op_wait       = 3'd4,
    op_data       = 3'd5
  } cmd_op_t;

  typedef struct packed {
    cmd_op_t          op;
    logic [arg_w-1:0] arg;
  } cmd_word_t;

  // downstream flow modes
  typedef enum logic [1:0] {run, stall, squash} gov_state_t;

endpackage

// File: logic/time_cfg_if.sv
`timescale 1ns/1ps

// clock configuration from the command decoder
interface time_cfg_if import time_pkg::*; ();

  unit_len_t  unit_len;
  epoch_len_t epoch_len;
  // last epoch count reported by the host
  epoch_t     host_epoch;
  // one-cycle strobe, restarts the wall clock
  logic       reset_time;

  modport src (
    output unit_len, epoch_len, host_epoch, reset_time
  );

  modport clk_sink (
    input unit_len, epoch_len, reset_time
  );

  modport gov_sink (
    input host_epoch
  );

endinterface

// File: logic/req_ack_sender.sv
`timescale 1ns/1ps

// four-phase sender fed from a one-entry load register
module req_ack_sender #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     load,
  input  payload_t load_data,
  output logic     load_ready,
  output logic     req,
  input  logic     ack,
  output payload_t data
);

  logic take;

  // idle only once the receiver has dropped ack
  assign load_ready = !req && !ack;
  assign take = load && load_ready;

  // req up the cycle after load, down once ack is seen
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req <= 1'b0;
    end else if (take) begin
      req <= 1'b1;
    end else if (req && ack) begin
      req <= 1'b0;
    end
  end

  // holding register
  always_ff @(posedge clk) begin
    if (take) begin
      data <= load_data;
    end
  end

  // receiver may sample data any time req is up
  assert property (@(posedge clk) disable iff (reset) req |=> $stable(data));

endmodule

// File: logic/host_cmd_decoder.sv
`timescale 1ns/1ps

// four-phase receiver for host command words
module host_cmd_decoder import time_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         cmd_req,
  output logic         cmd_ack,
  input  cmd_word_t    cmd_data,
  time_cfg_if.src      cfg,
  output logic         wait_req,
  output epoch_len_t   wait_units,
  input  logic         wait_ack,
  input  logic         stall,
  output logic         load,
  output stream_word_t load_data,
  input  logic         load_ready
);

  // idle: waiting for req, data: waiting for the sender,
  // wait: waiting on the governor, hold: ack high until req drops
  typedef enum logic [1:0] {d_idle, d_data, d_wait, d_hold} dec_state_t;

  dec_state_t state;
  logic       data_go;

  // sender free and no wait running
  assign data_go = load_ready && !stall;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state          <= d_idle;
      cmd_ack        <= 1'b0;
      wait_req       <= 1'b0;
      load           <= 1'b0;
      cfg.unit_len   <= unit_len_t'(1);
      cfg.epoch_len  <= epoch_len_t'(1);
      cfg.host_epoch <= '0;
      cfg.reset_time <= 1'b0;
    end else begin
      // strobes last one cycle
      load           <= 1'b0;
      cfg.reset_time <= 1'b0;
      case (state)
        d_idle: begin
          if (cmd_req) begin
            case (cmd_data.op)
              op_unit_len: begin
                cfg.unit_len <= cmd_data.arg[unit_len_w-1:0];
                cmd_ack      <= 1'b1;
                state        <= d_hold;
              end
              op_epoch_len: begin
                cfg.epoch_len <= cmd_data.arg[epoch_len_w-1:0];
                cmd_ack       <= 1'b1;
                state         <= d_hold;
              end
              op_reset_time: begin
                cfg.reset_time <= 1'b1;
                cmd_ack        <= 1'b1;
                state          <= d_hold;
              end
              op_host_epoch: begin
                cfg.host_epoch <= epoch_t'(cmd_data.arg);
                cmd_ack        <= 1'b1;
                state          <= d_hold;
              end
              op_wait: begin
                // governor acks, then the host gets its ack
                wait_req <= 1'b1;
                state    <= d_wait;
              end
              op_data: begin
                if (data_go) begin
                  load    <= 1'b1;
                  cmd_ack <= 1'b1;
                  state   <= d_hold;
                end else begin
                  state <= d_data;
                end
              end
              default: begin
                // unknown code, just ack
                cmd_ack <= 1'b1;
                state   <= d_hold;
              end
            endcase
          end
        end
        d_data: begin
          if (data_go) begin
            load    <= 1'b1;
            cmd_ack <= 1'b1;
            state   <= d_hold;
          end
        end
        d_wait: begin
          if (wait_ack) begin
            wait_req <= 1'b0;
            cmd_ack  <= 1'b1;
            state    <= d_hold;
          end
        end
        d_hold: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= d_idle;
          end
        end
        default: state <= d_idle;
      endcase
    end
  end

  // argument latched on req, host keeps it stable until ack
  always_ff @(posedge clk) begin
    if (state == d_idle && cmd_req) begin
      wait_units <= cmd_data.arg[epoch_len_w-1:0];
      load_data  <= cmd_data.arg;
    end
  end

  // ack only ever answers a pending request
  assert property (@(posedge clk) disable iff (reset) $rose(cmd_ack) |-> $past(cmd_req));

endmodule

// File: logic/wall_clock.sv
`timescale 1ns/1ps

// epoch and intra-epoch wall clock with heartbeat trigger
module wall_clock import time_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  time_cfg_if.clk_sink cfg,
  output logic         unit_pulse,
  output epoch_t       epochs,
  output logic         rollover,
  input  logic         hb_busy,
  output logic         hb_load,
  output epoch_t       hb_value
);

  unit_len_t            clk_cnt;
  logic [unit_len_w:0]  cnt_next;
  epoch_len_t           units;
  logic                 hb_pending;

  // one bit wider so a unit_len of 0 behaves like 1
  assign cnt_next = {1'b0, clk_cnt} + (unit_len_w + 1)'(1);

  // unit pulse every unit_len clocks
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      clk_cnt    <= '0;
      unit_pulse <= 1'b0;
    end else if (cfg.reset_time) begin
      clk_cnt    <= '0;
      unit_pulse <= 1'b0;
    end else if (cnt_next >= {1'b0, cfg.unit_len}) begin
      clk_cnt    <= '0;
      unit_pulse <= 1'b1;
    end else begin
      clk_cnt    <= cnt_next[unit_len_w-1:0];
      unit_pulse <= 1'b0;
    end
  end

  // last unit of the epoch just ended
  assign rollover = unit_pulse && !cfg.reset_time && (units >= cfg.epoch_len);

  // units run 1..epoch_len, epochs count rollovers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      units  <= '0;
      epochs <= '0;
    end else if (cfg.reset_time) begin
      units  <= epoch_len_t'(1);
      epochs <= '0;
    end else if (rollover) begin
      units  <= epoch_len_t'(1);
      epochs <= epochs + epoch_t'(1);
    end else if (unit_pulse) begin
      units <= units + epoch_len_t'(1);
    end
  end

  // heartbeat goes out at once or as soon as the sender frees up
  assign hb_load = (rollover || hb_pending) && !hb_busy;
  // count after this rollover, else the live count for a late one
  assign hb_value = rollover ? epochs + epoch_t'(1) : epochs;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hb_pending <= 1'b0;
    end else if (hb_load) begin
      hb_pending <= 1'b0;
    end else if (rollover) begin
      hb_pending <= 1'b1;
    end
  end

endmodule

// File: logic/flow_governor.sv
`timescale 1ns/1ps

// run/stall/squash control of downstream traffic
module flow_governor import time_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  time_cfg_if.gov_sink cfg,
  input  epoch_t       epochs,
  input  logic         unit_pulse,
  input  logic         wait_req,
  input  epoch_len_t   wait_units,
  output logic         wait_ack,
  output logic         stall,
  output logic         squash
);

  gov_state_t state;
  epoch_len_t countdown;
  logic       lagging;
  logic       new_wait;

  // host is more than squash_thr epochs behind the wall clock
  assign lagging = {1'b0, epochs} >
                   ({1'b0, cfg.host_epoch} + (epoch_w + 1)'(squash_thr));

  // request not yet answered
  assign new_wait = wait_req && !wait_ack;

  // outputs straight from the state
  assign stall  = (state == time_pkg::stall);
  assign squash = (state == time_pkg::squash);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= run;
      countdown <= '0;
    end else begin
      case (state)
        run: begin
          if (lagging) begin
            state <= time_pkg::squash;
          end else if (new_wait) begin
            state     <= time_pkg::stall;
            countdown <= wait_units;
          end
        end
        time_pkg::stall: begin
          if (lagging) begin
            // host fell behind mid-wait, drop the rest of it
            state     <= time_pkg::squash;
            countdown <= '0;
          end else if (countdown == '0) begin
            state <= run;
          end else if (unit_pulse) begin
            countdown <= countdown - epoch_len_t'(1);
          end
        end
        time_pkg::squash: begin
          if (!lagging) begin
            state <= run;
          end
        end
        default: state <= run;
      endcase
    end
  end

  // ack in run or squash, held until req drops
  // a request arriving during a stall waits for run
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wait_ack <= 1'b0;
    end else if (!wait_req) begin
      wait_ack <= 1'b0;
    end else if (state != time_pkg::stall) begin
      wait_ack <= 1'b1;
    end
  end

  // every way back into run leaves the countdown empty
  assert property (@(posedge clk) disable iff (reset) state == run |-> countdown == '0);

  // decoder keeps its request up until the ack comes back
  assert property (@(posedge clk) disable iff (reset) wait_req && !wait_ack |=> wait_req);

endmodule

// File: logic/epoch_sync_top.sv
`timescale 1ns/1ps

// epoch synchronizer between host link and device stream
module epoch_sync_top import time_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         cmd_req,
  output logic         cmd_ack,
  input  cmd_word_t    cmd_data,
  output logic         hb_req,
  input  logic         hb_ack,
  output epoch_t       hb_epoch,
  output logic         dn_req,
  input  logic         dn_ack,
  output stream_word_t dn_data,
  output logic         stall,
  output logic         squash
);

  // configuration from decoder to clock and governor
  time_cfg_if cfg ();

  // wait channel
  logic         wait_req;
  logic         wait_ack;
  epoch_len_t   wait_units;

  // data load into the downstream sender
  logic         load;
  logic         load_ready;
  stream_word_t load_data;

  // wall clock outputs
  logic         unit_pulse;
  epoch_t       epochs;

  // heartbeat load
  logic         hb_load;
  logic         hb_ready;
  epoch_t       hb_value;

  host_cmd_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .cmd_data   (cmd_data),
    .cfg        (cfg.src),
    .wait_req   (wait_req),
    .wait_units (wait_units),
    .wait_ack   (wait_ack),
    .stall      (stall),
    .load       (load),
    .load_data  (load_data),
    .load_ready (load_ready)
  );

  // rollover is folded into hb_load inside the clock
  wall_clock u_clock (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg.clk_sink),
    .unit_pulse (unit_pulse),
    .epochs     (epochs),
    .rollover   (),
    .hb_busy    (!hb_ready),
    .hb_load    (hb_load),
    .hb_value   (hb_value)
  );

  flow_governor u_governor (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg.gov_sink),
    .epochs     (epochs),
    .unit_pulse (unit_pulse),
    .wait_req   (wait_req),
    .wait_units (wait_units),
    .wait_ack   (wait_ack),
    .stall      (stall),
    .squash     (squash)
  );

  // heartbeat upstream
  req_ack_sender #(.payload_t(epoch_t)) u_hb_sender (
    .clk        (clk),
    .reset      (reset),
    .load       (hb_load),
    .load_data  (hb_value),
    .load_ready (hb_ready),
    .req        (hb_req),
    .ack        (hb_ack),
    .data       (hb_epoch)
  );

  // data words downstream
  req_ack_sender #(.payload_t(stream_word_t)) u_dn_sender (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .load_data  (load_data),
    .load_ready (load_ready),
    .req        (dn_req),
    .ack        (dn_ack),
    .data       (dn_data)
  );

endmodule

// File: tb/epoch_sync_tb.sv
`timescale 1ns/1ps

module epoch_sync_tb import time_pkg::*; ();

  // step kinds of the table
  localparam int k_cmd = 0, k_restart = 1, k_hb_seq = 2, k_data = 3, k_data_late = 4;
  localparam int k_data_fast = 5, k_wait_stall = 6, k_wait_squash = 7, k_squash_on = 8;
  localparam int k_host_sync = 9, k_hb_hold = 10;

  logic clk, reset, cmd_req, cmd_ack, hb_req, hb_ack, dn_req, dn_ack, stall, squash;
  cmd_word_t cmd_data;
  epoch_t hb_epoch;
  stream_word_t dn_data;

  // test table
  string name_q[$];
  int kind_q[$];
  cmd_word_t cmd_q[$];

  // what the models saw, one entry per req rise
  epoch_t hb_vals[$];
  int hb_cyc[$];
  stream_word_t dn_vals[$];
  int dn_cyc[$];
  logic hb_prev, dn_prev, hb_hold;
  int cycle, errors, tests, hb_next, dn_next, restart_cyc, wait_ack_cyc, ack_cyc, start_cyc;
  logic stall_at_ack, squash_at_ack;

  epoch_sync_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cycle counter and req-rise monitors
  always @(posedge clk) begin
    cycle <= cycle + 1;
    hb_prev <= hb_req;
    dn_prev <= dn_req;
    if (hb_req && !hb_prev) begin
      hb_vals.push_back(hb_epoch);
      hb_cyc.push_back(cycle);
    end
    if (dn_req && !dn_prev) begin
      dn_vals.push_back(dn_data);
      dn_cyc.push_back(cycle);
    end
  end

  // host side of the heartbeat port, prompt unless held
  always @(posedge clk) begin
    if (hb_req && !hb_ack && !hb_hold) hb_ack <= 1'b1;
    else if (!hb_req && hb_ack) hb_ack <= 1'b0;
  end

  // device side, 0 to 5 cycles before ack
  initial begin
    int d;
    void'($urandom(65));
    forever begin
      @(posedge clk);
      if (dn_req && !dn_ack) begin
        d = $urandom % 6;
        repeat (d) @(posedge clk);
        dn_ack <= 1'b1;
      end else if (!dn_req && dn_ack) begin
        dn_ack <= 1'b0;
      end
    end
  end

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_epoch(input string name, input epoch_t exp, input epoch_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input stream_word_t exp, input stream_word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected 0x%07h actual 0x%07h", name, exp, act);
      errors++;
    end
  endtask

  // full four-phase transfer of one command word
  task automatic send_cmd(input cmd_word_t w);
    int t;
    @(posedge clk);
    start_cyc = cycle;
    cmd_data <= w;
    cmd_req <= 1'b1;
    t = 0;
    while (!cmd_ack && t < 400) begin
      @(posedge clk);
      t++;
    end
    if (!cmd_ack) fail_msg("timeout: command was never acknowledged");
    ack_cyc = cycle;
    stall_at_ack = stall;
    squash_at_ack = squash;
    cmd_req <= 1'b0;
    t = 0;
    while (cmd_ack && t < 20) begin
      @(posedge clk);
      t++;
    end
    if (cmd_ack) fail_msg("timeout: command ack stayed high after req dropped");
  endtask

  task automatic add_step(input string name, input int kind, input cmd_op_t op, input int arg);
    cmd_word_t w;
    w.op = op;
    w.arg = arg[arg_w-1:0];
    name_q.push_back(name);
    kind_q.push_back(kind);
    cmd_q.push_back(w);
  endtask

  // next downstream word, returns 0 on timeout
  task automatic next_dn(output bit ok);
    int t;
    t = 0;
    while (dn_vals.size() <= dn_next && t < 400) begin
      @(posedge clk);
      t++;
    end
    ok = dn_vals.size() > dn_next;
    if (!ok) fail_msg("timeout: no word arrived downstream");
  endtask

  task automatic run_step(input int i);
    string nm;
    cmd_word_t w;
    epoch_t v[3];
    int c[3];
    int got, t, n;
    bit ok;
    nm = name_q[i];
    w = cmd_q[i];
    case (kind_q[i])
      k_cmd: send_cmd(w);
      k_restart: begin
        send_cmd(w);
        restart_cyc = start_cyc;
        hb_next = hb_vals.size();
      end
      k_hb_seq: begin
        // skip leftovers from before the restart, report each epoch back
        got = 0;
        t = 0;
        while (got < 3 && t < 300) begin
          if (hb_next < hb_vals.size()) begin
            if (hb_cyc[hb_next] > restart_cyc + 10) begin
              v[got] = hb_vals[hb_next];
              c[got] = hb_cyc[hb_next];
              got++;
              w.op = op_host_epoch;
              w.arg = v[got-1][arg_w-1:0];
              send_cmd(w);
            end
            hb_next++;
          end else begin
            @(posedge clk);
            t++;
          end
        end
        if (got < 3) fail_msg("timeout: fewer than three heartbeats");
        else begin
          for (n = 0; n < 3; n++) check_epoch(nm, epoch_t'(n + 1), v[n]);
          check_epoch({nm, " spacing"}, 16, epoch_t'(c[1] - c[0]));
          check_epoch({nm, " spacing"}, 16, epoch_t'(c[2] - c[1]));
        end
      end
      k_data, k_data_late, k_data_fast: begin
        send_cmd(w);
        next_dn(ok);
        if (ok) begin
          check_word(nm, w.arg, dn_vals[dn_next]);
          // unit is 4 clocks, wait was 5 units
          if (kind_q[i] == k_data_late &&
              (dn_cyc[dn_next] - wait_ack_cyc < 16 || dn_cyc[dn_next] - wait_ack_cyc > 30))
            fail_msg($sformatf("%s: word left %0d cycles after the wait ack, outside 16..30",
                               nm, dn_cyc[dn_next] - wait_ack_cyc));
          if (kind_q[i] == k_data_fast && dn_cyc[dn_next] - start_cyc > 10)
            fail_msg($sformatf("%s: word held back during squash", nm));
          dn_next++;
        end
      end
      k_wait_stall: begin
        send_cmd(w);
        wait_ack_cyc = ack_cyc;
        if (!stall_at_ack) fail_msg($sformatf("%s: stall did not rise for the wait", nm));
      end
      k_wait_squash: begin
        send_cmd(w);
        if (stall_at_ack || !squash_at_ack)
          fail_msg($sformatf("%s: wait was not discarded under squash", nm));
      end
      k_squash_on: begin
        t = 0;
        while (!squash && t < 200) begin
          @(posedge clk);
          t++;
        end
        if (!squash) fail_msg("timeout: squash never rose while the host lagged");
      end
      k_host_sync: begin
        // host reports the newest heartbeat it got
        w.arg = hb_vals[hb_vals.size()-1][arg_w-1:0];
        send_cmd(w);
        t = 0;
        while (squash && t < 20) begin
          @(posedge clk);
          t++;
        end
        if (squash) fail_msg("timeout: squash stayed high after the host caught up");
      end
      k_hb_hold: begin
        hb_hold <= 1'b1;
        @(posedge clk);
        t = 0;
        while (!(hb_req && !hb_ack) && t < 100) begin
          @(posedge clk);
          t++;
        end
        if (!(hb_req && !hb_ack)) fail_msg("timeout: no heartbeat to hold");
        v[0] = hb_epoch;
        // three epochs of 8 clocks
        repeat (24) @(posedge clk);
        n = hb_vals.size();
        hb_hold <= 1'b0;
        t = 0;
        while (hb_vals.size() < n + 1 && t < 100) begin
          @(posedge clk);
          t++;
        end
        if (hb_vals.size() < n + 1) fail_msg("timeout: heartbeats did not resume");
        else begin
          if (hb_vals[n] < v[0] + 2)
            fail_msg($sformatf("%s: late heartbeat %0d not two epochs past %0d",
                               nm, hb_vals[n], v[0]));
          // one epoch per 8 clocks since the held heartbeat went up
          check_epoch(nm, v[0] + epoch_t'((hb_cyc[n] - hb_cyc[n-1]) / 8), hb_vals[n]);
        end
      end
      default: fail_msg("unknown table step");
    endcase
  endtask

  initial begin
    int e0;
    reset = 1'b1;
    cmd_req = 1'b0;
    cmd_data = '0;
    hb_ack = 1'b0;
    dn_ack = 1'b0;
    hb_hold = 1'b0;
    hb_prev = 1'b0;
    dn_prev = 1'b0;
    cycle = 0;
    errors = 0;
    tests = 0;
    hb_next = 0;
    dn_next = 0;

    add_step("unit_len_4", k_cmd, op_unit_len, 4);
    add_step("epoch_len_4", k_cmd, op_epoch_len, 4);
    add_step("restart_a", k_restart, op_reset_time, 0);
    add_step("heartbeat_seq", k_hb_seq, op_host_epoch, 0);
    add_step("epoch_len_long", k_cmd, op_epoch_len, 1000);
    add_step("restart_b", k_restart, op_reset_time, 0);
    add_step("host_epoch_0", k_cmd, op_host_epoch, 0);
    add_step("data_a", k_data, op_data, 'h1234567);
    add_step("data_b", k_data, op_data, 'h0abcdef);
    add_step("data_c", k_data, op_data, 'h1fffffff);
    add_step("wait_5", k_wait_stall, op_wait, 5);
    add_step("data_after_wait", k_data_late, op_data, 'h0055aa0);
    add_step("epoch_len_2", k_cmd, op_epoch_len, 2);
    add_step("restart_c", k_restart, op_reset_time, 0);
    add_step("host_epoch_0b", k_cmd, op_host_epoch, 0);
    add_step("squash_rise", k_squash_on, op_host_epoch, 0);
    add_step("wait_squashed", k_wait_squash, op_wait, 5);
    add_step("data_in_squash", k_data_fast, op_data, 'h13579bd);
    add_step("epoch_len_freeze", k_cmd, op_epoch_len, 1000);
    add_step("host_catch_up", k_host_sync, op_host_epoch, 0);
    add_step("wait_3", k_wait_stall, op_wait, 3);
    add_step("data_recovered", k_data, op_data, 'h0f0f0f0);
    add_step("epoch_len_2b", k_cmd, op_epoch_len, 2);
    add_step("restart_d", k_restart, op_reset_time, 0);
    add_step("hb_backpressure", k_hb_hold, op_host_epoch, 0);

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    for (int i = 0; i < name_q.size(); i++) begin
      e0 = errors;
      run_step(i);
      tests++;
      $display("%s %s", (errors == e0) ? "[ok] " : "[bad]", name_q[i]);
    end

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // backstop in case a model wedges
  initial begin
    repeat (20000) @(posedge clk);
    $display("timeout: run exceeded its cycle limit");
    $display("Test failed");
    $finish;
  end

endmodule

// File: sources.f
logic/time_pkg.sv
logic/time_cfg_if.sv
logic/req_ack_sender.sv
logic/host_cmd_decoder.sv
logic/wall_clock.sv
logic/flow_governor.sv
logic/epoch_sync_top.sv
tb/epoch_sync_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the epoch synchronizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module epoch_sync_tb -o epoch_sync_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/epoch_sync_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
